//--- rtl/fedp_cfg.svh
`ifndef FEDP_CFG_SVH
`define FEDP_CFG_SVH

`default_nettype none

// Product lanes, the c term is one extra lane in the aligner
`define FEDP_LANES 4

// Operand and result words
`define FEDP_WORD_W 16
`define FEDP_DATA_W 32

// Datapath widths
`define FEDP_EXP_W 10
`define FEDP_SIG_W 25
`define FEDP_ALN_W (`FEDP_SIG_W + 2)
`define FEDP_SUM_W 30

`define FEDP_BIAS 127

// Cycles from request to result
`define FEDP_LATENCY 3

`default_nettype wire

`endif

//--- rtl/fedp_fmt_pkg.sv
`default_nettype none

package fedp_fmt_pkg;

    // Mode opcode carried with every request
    typedef enum logic {
        OP_BF16 = 1'b0,
        OP_INT8 = 1'b1
    } fedp_op_e;

    typedef struct packed {
        logic       sign;
        logic [7:0] exponent;
        logic [6:0] mantissa;
    } bf16_t;

    typedef struct packed {
        logic        sign;
        logic [7:0]  exponent;
        logic [22:0] mantissa;
    } fp32_t;

endpackage

`default_nettype wire

//--- rtl/fedp_pipe_pkg.sv
`include "fedp_cfg.svh"

`default_nettype none

package fedp_pipe_pkg;
    import fedp_fmt_pkg::*;

    // Incoming request, a and b are bf16 or int8 in the low byte
    typedef struct packed {
        fedp_op_e                                 op;
        logic [`FEDP_LANES-1:0][`FEDP_WORD_W-1:0] a;
        logic [`FEDP_LANES-1:0][`FEDP_WORD_W-1:0] b;
        logic [`FEDP_DATA_W-1:0]                  c;
    } fedp_req_t;

    // Decode to execute, lane FEDP_LANES is the c term
    typedef struct packed {
        fedp_op_e                               op;
        logic [`FEDP_LANES:0][`FEDP_EXP_W-1:0]  exps;
        logic [`FEDP_EXP_W-1:0]                 max_exp;
        logic [`FEDP_LANES:0][`FEDP_SIG_W-1:0]  sigs;
    } fedp_dec_t;

    // Execute to result
    typedef struct packed {
        fedp_op_e                      op;
        logic signed [`FEDP_SUM_W-1:0] acc;
        logic [`FEDP_EXP_W-1:0]        max_exp;
        logic                          sticky;
    } fedp_sum_t;

endpackage

`default_nettype wire

//--- rtl/fedp_align.sv
`include "fedp_cfg.svh"

`timescale 1ns/1ps
`default_nettype none

module fedp_align #(
    parameter int N     = `FEDP_LANES + 1,
    parameter int WI    = `FEDP_SIG_W,
    parameter int WO    = `FEDP_ALN_W,
    parameter int EXP_W = `FEDP_EXP_W
) (
    input  logic [N-1:0][EXP_W-1:0] exponents,
    input  logic [EXP_W-1:0]        max_exp,
    input  logic [N-1:0][WI-1:0]    sigs_in,
    input  logic                    is_int,
    output logic [N-1:0][WO-1:0]    sigs_out,
    output logic [N-1:0]            sticky_bits
);
    // Products get one more pre-shift bit than the c term
    localparam int PRE_W = WI - 23;
    localparam int MAG_W = WI - 1 + PRE_W;

    for (genvar i = 0; i < N; i++) begin : g_lane
        logic [EXP_W-1:0]   exp_diff;
        logic [7:0]         shift;
        logic [MAG_W-1:0]   mag_pre;
        logic [2*MAG_W-1:0] shifted;
        logic               overshift;
        logic [WO-2:0]      mag_aln;
        logic [WO-1:0]      fp_sig;

        // Saturate the exponent difference at 255
        assign exp_diff = max_exp - exponents[i];
        assign shift    = (|exp_diff[EXP_W-1:8]) ? 8'hff : exp_diff[7:0];

        if (i == N - 1) begin : g_c_term
            assign mag_pre = {1'b0, sigs_in[i][WI-2:0], {(PRE_W-1){1'b0}}};
        end else begin : g_prod_term
            assign mag_pre = {sigs_in[i][WI-2:0], {PRE_W{1'b0}}};
        end

        // Low half collects the bits shifted out
        assign shifted   = {mag_pre, {MAG_W{1'b0}}} >> shift;
        assign overshift = (shift >= MAG_W);
        assign mag_aln   = overshift ? '0 : shifted[MAG_W +: (WO-1)];

        assign fp_sig = sigs_in[i][WI-1] ? -{1'b0, mag_aln} : {1'b0, mag_aln};

        assign sigs_out[i]    = is_int ? WO'($signed(sigs_in[i])) : fp_sig;
        assign sticky_bits[i] = !is_int && (overshift ? (|mag_pre) : (|shifted[MAG_W-1:0]));
    end

endmodule

`default_nettype wire

//--- rtl/fedp_decode.sv
`include "fedp_cfg.svh"

`timescale 1ns/1ps
`default_nettype none

module fedp_decode import fedp_fmt_pkg::*, fedp_pipe_pkg::*; (
    input  logic      clk,
    input  logic      arst_n,
    input  logic      req_valid,
    input  fedp_req_t req,
    output logic      dec_valid,
    output fedp_dec_t dec
);
    // Zero lanes take the most negative exponent so they never win the max
    localparam logic [`FEDP_EXP_W-1:0] EXP_MIN = {1'b1, {(`FEDP_EXP_W-1){1'b0}}};

    logic                                  is_int;
    logic [`FEDP_LANES:0][`FEDP_EXP_W-1:0] lane_exp;
    logic [`FEDP_LANES:0][`FEDP_SIG_W-1:0] lane_sig;
    logic [`FEDP_EXP_W-1:0]                max_exp;
    fp32_t                                 op_c;

    assign is_int = (req.op == OP_INT8);

    for (genvar i = 0; i < `FEDP_LANES; i++) begin : g_prod
        bf16_t                  op_a;
        bf16_t                  op_b;
        logic                   lane_zero;
        logic [15:0]            prod_f;
        logic signed [15:0]     prod_i;
        logic [`FEDP_EXP_W-1:0] exp_sum;

        assign op_a      = req.a[i];
        assign op_b      = req.b[i];
        assign lane_zero = (op_a.exponent == 8'd0) || (op_b.exponent == 8'd0);

        // Hidden-bit significands give a 2.14 product
        assign prod_f  = {1'b1, op_a.mantissa} * {1'b1, op_b.mantissa};
        assign prod_i  = $signed(req.a[i][7:0]) * $signed(req.b[i][7:0]);
        assign exp_sum = `FEDP_EXP_W'(op_a.exponent) + `FEDP_EXP_W'(op_b.exponent)
                       - `FEDP_EXP_W'(`FEDP_BIAS);

        assign lane_exp[i] = is_int    ? '0 :
                             lane_zero ? EXP_MIN : exp_sum;
        assign lane_sig[i] = is_int    ? {{(`FEDP_SIG_W-16){prod_i[15]}}, prod_i} :
                             lane_zero ? '0 :
                             {op_a.sign ^ op_b.sign, prod_f, {(`FEDP_SIG_W-17){1'b0}}};
    end

    // c term, fp32 or a 24-bit signed integer
    assign op_c = req.c;

    assign lane_exp[`FEDP_LANES] = is_int ? '0 :
                                   (op_c.exponent == 8'd0) ? EXP_MIN :
                                   `FEDP_EXP_W'(op_c.exponent);
    assign lane_sig[`FEDP_LANES] = is_int ? {{(`FEDP_SIG_W-24){req.c[23]}}, req.c[23:0]} :
                                   (op_c.exponent == 8'd0) ? '0 :
                                   {op_c.sign, 1'b1, op_c.mantissa};

    // Lane exponents are signed
    always_comb begin
        max_exp = lane_exp[0];
        for (int i = 1; i <= `FEDP_LANES; i++) begin
            if ($signed(lane_exp[i]) > $signed(max_exp)) begin
                max_exp = lane_exp[i];
            end
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            dec_valid <= 1'b0;
        end else begin
            dec_valid <= req_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (req_valid) begin
            dec.op      <= req.op;
            dec.exps    <= lane_exp;
            dec.max_exp <= max_exp;
            dec.sigs    <= lane_sig;
        end
    end

endmodule

`default_nettype wire

//--- rtl/fedp_execute.sv
`include "fedp_cfg.svh"

`timescale 1ns/1ps
`default_nettype none

module fedp_execute import fedp_fmt_pkg::*, fedp_pipe_pkg::*; (
    input  logic      clk,
    input  logic      arst_n,
    input  logic      dec_valid,
    input  fedp_dec_t dec,
    output logic      sum_valid,
    output fedp_sum_t sum
);
    logic [`FEDP_LANES:0][`FEDP_ALN_W-1:0] aligned;
    logic [`FEDP_LANES:0]                  lane_sticky;
    logic [`FEDP_LANES:0][`FEDP_SUM_W-1:0] lane_ext;
    logic [`FEDP_SUM_W-1:0]                pair_lo;
    logic [`FEDP_SUM_W-1:0]                pair_hi;
    logic [`FEDP_SUM_W-1:0]                total;

    fedp_align #(
        .N     (`FEDP_LANES + 1),
        .WI    (`FEDP_SIG_W),
        .WO    (`FEDP_ALN_W),
        .EXP_W (`FEDP_EXP_W)
    ) i_fedp_align (
        .exponents   (dec.exps),
        .max_exp     (dec.max_exp),
        .sigs_in     (dec.sigs),
        .is_int      (dec.op == OP_INT8),
        .sigs_out    (aligned),
        .sticky_bits (lane_sticky)
    );

    for (genvar i = 0; i <= `FEDP_LANES; i++) begin : g_ext
        assign lane_ext[i] = {{(`FEDP_SUM_W-`FEDP_ALN_W){aligned[i][`FEDP_ALN_W-1]}},
                              aligned[i]};
    end

    // Two product pairs, then the c term joins
    assign pair_lo = lane_ext[0] + lane_ext[1];
    assign pair_hi = lane_ext[2] + lane_ext[3];
    assign total   = pair_lo + pair_hi + lane_ext[`FEDP_LANES];

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            sum_valid <= 1'b0;
        end else begin
            sum_valid <= dec_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (dec_valid) begin
            sum.op      <= dec.op;
            sum.acc     <= total;
            sum.max_exp <= dec.max_exp;
            sum.sticky  <= |lane_sticky;
        end
    end

endmodule

`default_nettype wire

//--- rtl/fedp_result.sv
`include "fedp_cfg.svh"

`timescale 1ns/1ps
`default_nettype none

module fedp_result import fedp_fmt_pkg::*, fedp_pipe_pkg::*; (
    input  logic                    clk,
    input  logic                    arst_n,
    input  logic                    sum_valid,
    input  fedp_sum_t               sum,
    output logic                    res_valid,
    output logic [`FEDP_DATA_W-1:0] res
);
    localparam int MAG_W   = `FEDP_SUM_W - 1;
    localparam int LZ_W    = $clog2(MAG_W);
    // Leading one at the top bit has weight 2^POINT_OFS
    localparam int POINT_OFS = MAG_W - `FEDP_SIG_W;
    localparam int FRAC_LO   = MAG_W - 24;

    logic                    sign;
    logic [`FEDP_SUM_W-1:0]  abs_acc;
    logic [MAG_W-1:0]        mag;
    logic [LZ_W-1:0]         lz;
    logic [MAG_W-1:0]        norm;
    logic [23:0]             sig;
    logic                    guard;
    logic                    rnd;
    logic                    round_up;
    logic [24:0]             sig_rnd;
    logic                    carry;
    logic [22:0]             mant;
    logic signed [11:0]      exp_calc;
    fp32_t                   res_fp;
    logic [`FEDP_DATA_W-1:0] res_int;
    logic [`FEDP_DATA_W-1:0] res_next;

    assign sign    = sum.acc[`FEDP_SUM_W-1];
    assign abs_acc = sign ? -sum.acc : sum.acc;
    assign mag     = abs_acc[MAG_W-1:0];

    // Highest set bit wins
    always_comb begin
        lz = '0;
        for (int i = 0; i < MAG_W; i++) begin
            if (mag[i]) begin
                lz = LZ_W'(MAG_W - 1 - i);
            end
        end
    end

    assign norm  = mag << lz;
    assign sig   = norm[MAG_W-1 -: 24];
    assign guard = norm[FRAC_LO-1];
    assign rnd   = (|norm[FRAC_LO-2:0]) | sum.sticky;

    // Nearest even
    assign round_up = guard & (rnd | sig[0]);
    assign sig_rnd  = {1'b0, sig} + 25'(round_up);
    assign carry    = sig_rnd[24];
    assign mant     = carry ? sig_rnd[23:1] : sig_rnd[22:0];

    assign exp_calc = $signed({{2{sum.max_exp[`FEDP_EXP_W-1]}}, sum.max_exp})
                    + 12'(POINT_OFS) - 12'(lz) + 12'(carry);

    always_comb begin
        if (mag == '0) begin
            res_fp = '0;
        end else if (exp_calc <= 0) begin
            res_fp = {sign, 31'd0};
        end else if (exp_calc >= 255) begin
            res_fp = {sign, 8'hff, 23'd0};
        end else begin
            res_fp = {sign, exp_calc[7:0], mant};
        end
    end

    assign res_int  = {{(`FEDP_DATA_W-`FEDP_SUM_W){sign}}, sum.acc};
    assign res_next = (sum.op == OP_INT8) ? res_int : res_fp;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            res_valid <= 1'b0;
        end else begin
            res_valid <= sum_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (sum_valid) begin
            res <= res_next;
        end
    end

endmodule

`default_nettype wire

//--- rtl/fedp_top.sv
`include "fedp_cfg.svh"

`timescale 1ns/1ps
`default_nettype none

module fedp_top import fedp_pipe_pkg::*; (
    input  logic                    clk,
    input  logic                    arst_n,
    input  logic                    req_valid,
    input  fedp_req_t               req,
    output logic                    res_valid,
    output logic [`FEDP_DATA_W-1:0] res
);
    logic      dec_valid;
    fedp_dec_t dec;
    logic      sum_valid;
    fedp_sum_t sum;

    fedp_decode i_fedp_decode (
        .clk       (clk),
        .arst_n    (arst_n),
        .req_valid (req_valid),
        .req       (req),
        .dec_valid (dec_valid),
        .dec       (dec)
    );

    fedp_execute i_fedp_execute (
        .clk       (clk),
        .arst_n    (arst_n),
        .dec_valid (dec_valid),
        .dec       (dec),
        .sum_valid (sum_valid),
        .sum       (sum)
    );

    fedp_result i_fedp_result (
        .clk       (clk),
        .arst_n    (arst_n),
        .sum_valid (sum_valid),
        .sum       (sum),
        .res_valid (res_valid),
        .res       (res)
    );

endmodule

`default_nettype wire

//--- sim/fedp_clk_gen.sv
`timescale 1ns/1ps
`default_nettype none

module fedp_clk_gen #(
    parameter int HALF_PERIOD  = 2,
    parameter int RESET_CYCLES = 16
) (
    output logic clk,
    output logic arst_n
);
    initial begin
        clk = 1'b0;
        forever #(HALF_PERIOD) clk = ~clk;
    end

    // Release on a falling edge, away from the sampling edge
    initial begin
        arst_n = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        arst_n = 1'b1;
    end

endmodule

`default_nettype wire

//--- sim/fedp_props.sv
`include "fedp_cfg.svh"

`timescale 1ns/1ps
`default_nettype none

module fedp_props (
    input logic                    clk,
    input logic                    arst_n,
    input logic                    req_valid,
    input logic                    res_valid,
    input logic [`FEDP_DATA_W-1:0] res
);
    // Fixed pipeline depth, no stalls
    a_latency: assert property (
        @(posedge clk) disable iff (!arst_n)
        res_valid == $past(req_valid, `FEDP_LATENCY)
    ) else $error("res_valid does not follow req_valid by the pipeline latency");

    a_res_known: assert property (
        @(posedge clk) disable iff (!arst_n)
        res_valid |-> !$isunknown(res)
    ) else $error("res holds X or Z while res_valid is high");

    a_reset_quiet: assert property (
        @(posedge clk) !arst_n |-> !res_valid
    ) else $error("res_valid is high during reset");

endmodule

bind fedp_top fedp_props i_fedp_props (
    .clk       (clk),
    .arst_n    (arst_n),
    .req_valid (req_valid),
    .res_valid (res_valid),
    .res       (res)
);

`default_nettype wire

//--- sim/fedp_tb.sv
`include "fedp_cfg.svh"

`timescale 1ns/1ps
`default_nettype none

module fedp_tb
    import fedp_fmt_pkg::*, fedp_pipe_pkg::*;
();
    localparam int NUM_ROWS    = 13;
    localparam int BURST_SPLIT = 7;
    localparam int GAP_CYCLES  = 3;
    localparam int MAX_CYCLES  = 16 + 2 * NUM_ROWS + 20;

    typedef struct packed {
        fedp_op_e                            op;
        logic [`FEDP_LANES*`FEDP_WORD_W-1:0] a;
        logic [`FEDP_LANES*`FEDP_WORD_W-1:0] b;
        logic [`FEDP_DATA_W-1:0]             c;
        logic [`FEDP_DATA_W-1:0]             expected;
    } vector_t;

    typedef struct packed {
        logic [7:0]  row;
        logic [31:0] expected;
        logic [31:0] issued;
    } pending_t;

    // Lane 3 on the left and lane 0 on the right
    vector_t vectors [NUM_ROWS] = '{
        // int8 sum of 5 - 12 - 21 - 32 and c = -100
        {OP_INT8, 64'h00FC_0003_00FE_0001, 64'h0008_00F9_0006_0005, 32'h00FFFF9C, 32'hFFFFFF60},
        // int8 with four times -128 * -128 and c = -1
        {OP_INT8, 64'h0080_0080_0080_0080, 64'h0080_0080_0080_0080, 32'h00FFFFFF, 32'h0000FFFF},
        // int8 with four times 127 * -128 and c = -2^23
        {OP_INT8, 64'h007F_007F_007F_007F, 64'h0080_0080_0080_0080, 32'h00800000, 32'hFF7F0200},
        // bf16 sum 4 * (1 * 2) + 1 = 9
        {OP_BF16, 64'h3F80_3F80_3F80_3F80, 64'h4000_4000_4000_4000, 32'h3F800000, 32'h41100000},
        // bf16 sum 6 - 3 + 2 + 2 - 2.5 = 4.5
        {OP_BF16, 64'h4080_3F00_BF80_4040, 64'h3F00_4080_4040_4000, 32'hC0200000, 32'h40900000},
        // bf16 sum 2.25 - 8 + 0.25 + 0.25 + 0.5 = -4.75
        {OP_BF16, 64'h3F80_3F80_C080_3FC0, 64'h3E80_3E80_4000_3FC0, 32'h3F000000, 32'hC0980000},
        // bf16 sum 1 + 2 - 1 + 1 - 3 cancels to +0
        {OP_BF16, 64'h3F00_BF80_4000_3F80, 64'h4000_3F80_3F80_3F80, 32'hC0400000, 32'h00000000},
        // 2^24 + 0.9375 truncates
        {OP_BF16, 64'h3D80_3E00_3E80_3F00, 64'h3F80_3F80_3F80_3F80, 32'h4B800000, 32'h4B800000},
        // 2^24 + 1.5 rounds up because the sticky bit breaks the tie
        {OP_BF16, 64'h3E00_3E00_3E80_3F80, 64'h3F80_3F80_3F80_3F80, 32'h4B800000, 32'h4B800001},
        // 2^24 + 1 is an exact tie and stays even
        {OP_BF16, 64'h0000_0000_0000_3F80, 64'h3F80_3F80_3F80_3F80, 32'h4B800000, 32'h4B800000},
        // (2^24 + 2) + 1 is a tie on an odd LSB and goes up to even
        {OP_BF16, 64'h0000_0000_0000_3F80, 64'h3F80_3F80_3F80_3F80, 32'h4B800001, 32'h4B800002},
        // Zero operands kill their lanes so only 6 + 2 = 8 is left
        {OP_BF16, 64'h3F80_4000_4000_0000, 64'h8000_4040_0000_7F00, 32'h40000000, 32'h41000000},
        // -2^-127 is below the smallest normal and flushes to -0
        {OP_BF16, 64'h0000_0000_0000_9F80, 64'h0000_0000_0000_2000, 32'h00000000, 32'h80000000}
    };

    logic                    clk;
    logic                    arst_n;
    logic                    req_valid;
    fedp_req_t               req;
    logic                    res_valid;
    logic [`FEDP_DATA_W-1:0] res;

    pending_t    pending_q [$];
    pending_t    head;
    logic [31:0] cycle_cnt = '0;

    fedp_clk_gen i_fedp_clk_gen (
        .clk    (clk),
        .arst_n (arst_n)
    );

    fedp_top i_fedp_top (
        .clk       (clk),
        .arst_n    (arst_n),
        .req_valid (req_valid),
        .req       (req),
        .res_valid (res_valid),
        .res       (res)
    );

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("Simulation FAILED");
        $fatal(1, "Run stopped at %0t", $time);
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] want);
        if (got !== want) begin
            abort_run($sformatf("CHECK FAILED at %0t: %s got 0x%08h, expected 0x%08h",
                                $time, name, got, want));
        end
    endtask

    task automatic apply_row(input int idx);
        pending_t entry;
        @(negedge clk);
        req_valid = 1'b1;
        req.op    = vectors[idx].op;
        req.a     = vectors[idx].a;
        req.b     = vectors[idx].b;
        req.c     = vectors[idx].c;
        entry.row      = 8'(idx);
        entry.expected = vectors[idx].expected;
        entry.issued   = cycle_cnt;
        pending_q.push_back(entry);
    endtask

    task automatic idle(input int cycles);
        repeat (cycles) begin
            @(negedge clk);
            req_valid = 1'b0;
            req       = '0;
        end
    endtask

    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= MAX_CYCLES) begin
            abort_run($sformatf("Timed out after %0d cycles waiting for results", cycle_cnt));
        end
    end

    // Each valid result is compared with the oldest expected value
    always @(negedge clk) begin
        if (cycle_cnt != 0) begin
            if (!arst_n) begin
                check_value("res_valid", res_valid, 1'b0);
            end else if (res_valid !== 1'b0) begin
                if (pending_q.size() == 0) begin
                    abort_run("An unexpected result appeared with no request outstanding");
                end else begin
                    head = pending_q.pop_front();
                    check_value($sformatf("res (row %0d)", head.row), res, head.expected);
                    check_value($sformatf("res latency (row %0d)", head.row),
                                cycle_cnt - head.issued, `FEDP_LATENCY);
                end
            end
        end
    end

    initial begin
        req_valid = 1'b0;
        req       = '0;
        wait (arst_n === 1'b1);
        // Two back-to-back bursts with a quiet gap between them
        for (int i = 0; i < NUM_ROWS; i++) begin
            if (i == BURST_SPLIT) begin
                idle(GAP_CYCLES);
            end
            apply_row(i);
        end
        idle(1);
        while (pending_q.size() != 0) begin
            @(negedge clk);
        end
        idle(`FEDP_LATENCY + 2);
        $display("Simulation PASSED");
        $finish;
    end

endmodule

`default_nettype wire

//--- fedp.f
+incdir+rtl
rtl/fedp_fmt_pkg.sv
rtl/fedp_pipe_pkg.sv
rtl/fedp_align.sv
rtl/fedp_decode.sv
rtl/fedp_execute.sv
rtl/fedp_result.sv
rtl/fedp_top.sv
sim/fedp_clk_gen.sv
sim/fedp_props.sv
sim/fedp_tb.sv
